// ==== filelist.f ====
+incdir+hw
hw/soc_pkg.sv
hw/soc_ifs.sv
hw/bus_fabric.sv
hw/mmio_regfile.sv
hw/gpio_pin_mux.sv
hw/soc_bus_top.sv
tb/soc_bus_checker.sv
tb/tb_soc_bus_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator and run it, exit status carries the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert \
  --top-module tb_soc_bus_top \
  -f filelist.f \
  -Mdir build/obj_dir &&
./build/obj_dir/Vtb_soc_bus_top ||
{ echo "simulation did not complete cleanly"; exit 1; }

// ==== tb/tb_soc_bus_top.sv ====
// testbench for soc_bus_top that acts as bus master and SRAM and checks read data and irq vector
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module tb_soc_bus_top;
  import soc_pkg::*;

  logic       clk_i;
  logic       rst_n_i;
  logic       mem_valid_i;
  word_t      mem_addr_i;
  word_t      mem_wdata_i;
  strb_t      mem_wstrb_i;
  logic       mem_ready_o;
  word_t      mem_rdata_o;
  strb_t      ram_wstrb_o;
  ram_addr_t  ram_addr_o;
  word_t      ram_wdata_o;
  word_t      ram_rdata_i;
  gpio_t      gpio_out_o;
  gpio_t      gpio_in_i;
  gpio_t      gpio_pullupb_o;
  gpio_t      gpio_pulldownb_o;
  gpio_t      gpio_outenb_o;
  logic [7:0]  hk_config_i;
  logic        hk_xtal_ena_i;
  logic        hk_reg_ena_i;
  logic        hk_pll_cp_ena_i;
  logic        hk_pll_vco_ena_i;
  logic        hk_pll_bias_ena_i;
  logic [3:0]  hk_pll_trim_i;
  logic [11:0] hk_mfgr_id_i;
  logic [7:0]  hk_prod_id_i;
  logic [3:0]  hk_mask_rev_i;
  logic        clk_ext_sel_i;
  logic        trap_i;
  logic        irq_pin_i;
  logic        irq_spi_i;
  irq_vec_t    irq_o;

  word_t sram [0:`SOC_MEM_WORDS-1];

  soc_bus_top uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // external sram model with asynchronous read
  assign ram_rdata_i = sram[ram_addr_o];

  always @(posedge clk_i) begin
    if (ram_wstrb_o[0]) sram[ram_addr_o][7:0] <= ram_wdata_o[7:0];
    if (ram_wstrb_o[1]) sram[ram_addr_o][15:8] <= ram_wdata_o[15:8];
    if (ram_wstrb_o[2]) sram[ram_addr_o][23:16] <= ram_wdata_o[23:16];
    if (ram_wstrb_o[3]) sram[ram_addr_o][31:24] <= ram_wdata_o[31:24];
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "simulation stopped at %0t ns", $time);
  endtask

  task automatic check_value(input string name, input word_t got, input word_t exp);
    string line;
    assert (got === exp) else begin
      line = $sformatf("Mismatch at %0t ns: %s is 0x%08h, expected 0x%08h",
                       $time, name, got, exp);
      abort_run(line);
    end
  endtask

  function automatic word_t byte_merge(word_t old, word_t upd, strb_t strb);
    word_t res;
    for (int b = 0; b < 4; b++) begin
      res[8*b +: 8] = strb[b] ? upd[8*b +: 8] : old[8*b +: 8];
    end
    return res;
  endfunction

  function automatic word_t reg_addr(logic [7:0] off);
    return {`SOC_MMIO_PAGE, off};
  endfunction

  // one request held until ready and sampled on the falling edge
  task automatic bus_access(input word_t addr, input word_t wdata, input strb_t strb,
                            output word_t rdata);
    int waited;
    @(posedge clk_i);
    mem_valid_i <= 1'b1;
    mem_addr_i  <= addr;
    mem_wdata_i <= wdata;
    mem_wstrb_i <= strb;
    waited = 0;
    @(negedge clk_i);
    while (!mem_ready_o) begin
      waited++;
      if (waited > 16) begin
        abort_run($sformatf("no ready from the bus for address 0x%08h", addr));
      end
      @(negedge clk_i);
    end
    rdata = mem_rdata_o;
    @(posedge clk_i);
    mem_valid_i <= 1'b0;
    mem_wstrb_i <= 4'h0;
  endtask

  task automatic bus_write(input word_t addr, input word_t wdata, input strb_t strb);
    word_t ignored;
    bus_access(addr, wdata, strb, ignored);
  endtask

  task automatic bus_read(input word_t addr, output word_t rdata);
    bus_access(addr, 32'h0, 4'h0, rdata);
  endtask

  initial begin
    word_t addr;
    word_t w0;
    word_t w1;
    word_t rd;
    word_t exp;
    strb_t strb;
    logic [31:0] rnd;
    logic [31:0] rnd_b;
    int src8;
    void'($urandom(48892));
    rst_n_i = 1'b0;
    mem_valid_i = 1'b0;
    mem_addr_i = '0;
    mem_wdata_i = '0;
    mem_wstrb_i = '0;
    gpio_in_i = '0;
    hk_config_i = '0;
    hk_xtal_ena_i = 1'b0;
    hk_reg_ena_i = 1'b0;
    hk_pll_cp_ena_i = 1'b0;
    hk_pll_vco_ena_i = 1'b0;
    hk_pll_bias_ena_i = 1'b0;
    hk_pll_trim_i = '0;
    hk_mfgr_id_i = '0;
    hk_prod_id_i = '0;
    hk_mask_rev_i = '0;
    clk_ext_sel_i = 1'b0;
    trap_i = 1'b0;
    irq_pin_i = 1'b0;
    irq_spi_i = 1'b0;
    for (int i = 0; i < `SOC_MEM_WORDS; i++) begin
      sram[i] = (i * 32'h0001_0003) ^ 32'hc3a5_0000;
    end
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // each sram word is read, written whole, written under strobes and read back
    for (int n = 0; n < 8; n++) begin
      addr = ($urandom % `SOC_MEM_WORDS) * 4;
      w0 = $urandom;
      w1 = $urandom;
      rnd = $urandom;
      strb = rnd[3:0];
      exp = sram[addr >> 2];
      bus_read(addr, rd);
      check_value("mem_rdata_o (before write)", rd, exp);
      bus_write(addr, w0, 4'hf);
      bus_write(addr, w1, strb);
      bus_read(addr, rd);
      check_value("mem_rdata_o", rd, byte_merge(w0, w1, strb));
    end

    // GPIO, OEB, PU and PD sit at consecutive words
    for (int r = 0; r < 4; r++) begin
      addr = reg_addr(8'(4 * r));
      w0 = $urandom;
      w1 = $urandom;
      rnd = $urandom;
      strb = rnd[3:0];
      gpio_in_i <= rnd[31:16];
      bus_write(addr, w0, 4'hf);
      bus_write(addr, w1, strb);
      bus_read(addr, rd);
      exp = byte_merge(w0, w1, strb) & 32'h0000_ffff;
      if (r == 0) begin
        check_value("mem_rdata_o[31:16]", {16'h0, rd[31:16]}, exp);
        check_value("gpio_out_o", {16'h0, gpio_out_o}, exp);
        check_value("mem_rdata_o[15:0]", {16'h0, rd[15:0]}, {16'h0, rnd[31:16]});
      end else begin
        check_value("mem_rdata_o", rd, exp);
        case (r)
          1: check_value("gpio_outenb_o", {16'h0, gpio_outenb_o}, exp);
          2: check_value("gpio_pullupb_o", {16'h0, gpio_pullupb_o}, exp);
          default: check_value("gpio_pulldownb_o", {16'h0, gpio_pulldownb_o}, exp);
        endcase
      end
    end

    // housekeeping status words
    @(posedge clk_i);
    rnd = $urandom;
    rnd_b = $urandom;
    hk_config_i <= rnd[7:0];
    hk_xtal_ena_i <= rnd[8];
    hk_reg_ena_i <= rnd[9];
    hk_pll_cp_ena_i <= rnd[10];
    hk_pll_vco_ena_i <= rnd[11];
    hk_pll_bias_ena_i <= rnd[12];
    hk_pll_trim_i <= rnd[16:13];
    hk_mask_rev_i <= rnd[20:17];
    hk_prod_id_i <= rnd[28:21];
    clk_ext_sel_i <= rnd[29];
    hk_mfgr_id_i <= rnd_b[11:0];
    bus_read(reg_addr(`SOC_REG_HK_CFG), rd);
    check_value("mem_rdata_o (hk config)", rd, {24'h0, rnd[7:0]});
    bus_read(reg_addr(`SOC_REG_HK_ENA), rd);
    check_value("mem_rdata_o (hk enables)", rd, {30'h0, rnd[8], rnd[9]});
    bus_read(reg_addr(`SOC_REG_HK_PLL), rd);
    check_value("mem_rdata_o (hk pll)", rd, {25'h0, rnd[16:13], rnd[10], rnd[11], rnd[12]});
    bus_read(reg_addr(`SOC_REG_HK_MFGR), rd);
    check_value("mem_rdata_o (hk mfgr id)", rd, {20'h0, rnd_b[11:0]});
    bus_read(reg_addr(`SOC_REG_HK_PROD), rd);
    check_value("mem_rdata_o (hk prod id)", rd, {24'h0, rnd[28:21]});
    bus_read(reg_addr(`SOC_REG_HK_MASK), rd);
    check_value("mem_rdata_o (hk mask rev)", rd, {28'h0, rnd[20:17]});
    bus_read(reg_addr(`SOC_REG_CLK_SEL), rd);
    check_value("mem_rdata_o (clk select)", rd, {31'h0, rnd[29]});

    // trap routed to each pad in turn while the checker watches the override
    for (int d = 1; d < 4; d++) begin
      bus_write(reg_addr(`SOC_REG_TRAP_DEST), word_t'(d), 4'h1);
      repeat (6) begin
        @(posedge clk_i);
        trap_i <= ~trap_i;
      end
    end
    bus_write(reg_addr(`SOC_REG_TRAP_DEST), 32'h0, 4'h1);

    for (int d = 1; d < 3; d++) begin
      bus_write(reg_addr(`SOC_REG_PLL_DEST), word_t'(d), 4'h1);
      @(negedge clk_i);
      check_value("gpio_out_o (pll pad, clock low)", {31'h0, gpio_out_o[7 + d]}, 32'h0);
      @(posedge clk_i);
      #2;
      check_value("gpio_out_o (pll pad, clock high)", {31'h0, gpio_out_o[7 + d]}, 32'h1);
    end
    bus_write(reg_addr(`SOC_REG_PLL_DEST), 32'h0, 4'h1);

    // irq 7 and 8 sources stepped through with random gpio_in and irq pins
    for (int s = 0; s < 4; s++) begin
      src8 = (s + 1) % 4;
      bus_write(reg_addr(`SOC_REG_IRQ7_SRC), word_t'(s), 4'h1);
      bus_write(reg_addr(`SOC_REG_IRQ8_SRC), word_t'(src8), 4'h1);
      repeat (4) begin
        @(posedge clk_i);
        rnd = $urandom;
        gpio_in_i <= rnd[15:0];
        irq_pin_i <= rnd[16];
        irq_spi_i <= rnd[17];
        @(negedge clk_i);
        exp = '0;
        exp[`SOC_IRQ_PIN] = rnd[16];
        exp[`SOC_IRQ_SPI] = rnd[17];
        if (s != 0) exp[`SOC_IRQ_7] = rnd[s - 1];
        if (src8 != 0) exp[`SOC_IRQ_8] = rnd[2 + src8];
        check_value("irq_o", irq_o, exp);
      end
    end

    repeat (2) @(posedge clk_i);
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/soc_bus_checker.sv ====
// concurrent assertions on bus timing, reset state and pad routing, bound into soc_bus_top
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module soc_bus_checker (
  input  wire                 clk_i,
  input  wire                 rst_n_i,
  input  wire                 mem_valid_i,
  input  soc_pkg::word_t      mem_addr_i,
  input  soc_pkg::strb_t      mem_wstrb_i,
  input  wire                 mem_ready_i,
  input  soc_pkg::word_t      mem_rdata_i,
  input  soc_pkg::strb_t      ram_wstrb_i,
  input  soc_pkg::word_t      ram_rdata_i,
  input  soc_pkg::gpio_t      gpio_out_i,
  input  soc_pkg::gpio_t      gpio_outenb_i,
  input  soc_pkg::gpio_t      gpio_pullupb_i,
  input  soc_pkg::gpio_t      gpio_pulldownb_i,
  input  wire                 trap_i,
  input  soc_pkg::pll_dest_e  pll_dest_i,
  input  soc_pkg::trap_dest_e trap_dest_i
);
  import soc_pkg::*;

  logic ram_hit;

  assign ram_hit = mem_valid_i && (mem_addr_i < `SOC_RAM_TOP);

  // pads off and bus idle in reset and on the first cycle out of it
  reset_quiet: assert property (@(posedge clk_i)
    (!rst_n_i || $rose(rst_n_i)) |->
      (gpio_outenb_i == '1 && !mem_ready_i && ram_wstrb_i == '0))
    else $error("pads enabled or bus active around reset");

  ready_next_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(mem_valid_i) |=> mem_ready_i)
    else $error("ready did not follow valid by one cycle");

  ready_one_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_ready_i |=> !mem_ready_i)
    else $error("ready stayed high for more than one cycle");

  ram_strobe_pass: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ram_hit && !mem_ready_i) |-> ram_wstrb_i == mem_wstrb_i)
    else $error("sram write strobe does not match the bus strobe");

  ram_read_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ram_hit && mem_ready_i) |-> mem_rdata_i == ram_rdata_i)
    else $error("bus read data differs from sram data");

  // trap group 11-13 driven, pulls off, routed pad follows trap
  trap_override: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (trap_dest_i != TRAP_NONE) |->
      (gpio_outenb_i[13:11] == 3'b000 && gpio_pullupb_i[13:11] == 3'b111 &&
       gpio_pulldownb_i[13:11] == 3'b111 && gpio_out_i[10 + int'(trap_dest_i)] == trap_i))
    else $error("trap pad override wrong");

  pll_override: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (pll_dest_i != PLL_NONE) |->
      (gpio_outenb_i[10:8] == 3'b000 && gpio_pullupb_i[10:8] == 3'b111 &&
       gpio_pulldownb_i[10:8] == 3'b111))
    else $error("pll pad override wrong");

endmodule

bind soc_bus_top soc_bus_checker u_checker (
  .clk_i            (clk_i),
  .rst_n_i          (rst_n_i),
  .mem_valid_i      (mem_valid_i),
  .mem_addr_i       (mem_addr_i),
  .mem_wstrb_i      (mem_wstrb_i),
  .mem_ready_i      (mem_ready_o),
  .mem_rdata_i      (mem_rdata_o),
  .ram_wstrb_i      (ram_wstrb_o),
  .ram_rdata_i      (ram_rdata_i),
  .gpio_out_i       (gpio_out_o),
  .gpio_outenb_i    (gpio_outenb_o),
  .gpio_pullupb_i   (gpio_pullupb_o),
  .gpio_pulldownb_i (gpio_pulldownb_o),
  .trap_i           (trap_i),
  .pll_dest_i       (u_pad_cfg.pll_dest),
  .trap_dest_i      (u_pad_cfg.trap_dest)
);

`default_nettype wire

// ==== hw/soc_bus_top.sv ====
// top level of the SoC bus fabric with native bus, SRAM, GPIO and status ports
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top (
  input  wire                 clk_i,
  input  wire                 rst_n_i,
  // native bus from the master
  input  wire                 mem_valid_i,
  input  soc_pkg::word_t      mem_addr_i,
  input  soc_pkg::word_t      mem_wdata_i,
  input  soc_pkg::strb_t      mem_wstrb_i,
  output logic                mem_ready_o,
  output soc_pkg::word_t      mem_rdata_o,
  // external sram
  output soc_pkg::strb_t      ram_wstrb_o,
  output soc_pkg::ram_addr_t  ram_addr_o,
  output soc_pkg::word_t      ram_wdata_o,
  input  soc_pkg::word_t      ram_rdata_i,
  // pads
  output soc_pkg::gpio_t      gpio_out_o,
  input  soc_pkg::gpio_t      gpio_in_i,
  output soc_pkg::gpio_t      gpio_pullupb_o,
  output soc_pkg::gpio_t      gpio_pulldownb_o,
  output soc_pkg::gpio_t      gpio_outenb_o,
  // housekeeping spi status
  input  wire [7:0]           hk_config_i,
  input  wire                 hk_xtal_ena_i,
  input  wire                 hk_reg_ena_i,
  input  wire                 hk_pll_cp_ena_i,
  input  wire                 hk_pll_vco_ena_i,
  input  wire                 hk_pll_bias_ena_i,
  input  wire [3:0]           hk_pll_trim_i,
  input  wire [11:0]          hk_mfgr_id_i,
  input  wire [7:0]           hk_prod_id_i,
  input  wire [3:0]           hk_mask_rev_i,
  input  wire                 clk_ext_sel_i,
  input  wire                 trap_i,
  input  wire                 irq_pin_i,
  input  wire                 irq_spi_i,
  output soc_pkg::irq_vec_t   irq_o
);

  mmio_bus_if u_mmio_bus ();
  pad_cfg_if  u_pad_cfg ();

  bus_fabric u_bus_fabric (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .mem_valid_i (mem_valid_i),
    .mem_addr_i  (mem_addr_i),
    .mem_wdata_i (mem_wdata_i),
    .mem_wstrb_i (mem_wstrb_i),
    .mem_ready_o (mem_ready_o),
    .mem_rdata_o (mem_rdata_o),
    .ram_wstrb_o (ram_wstrb_o),
    .ram_addr_o  (ram_addr_o),
    .ram_wdata_o (ram_wdata_o),
    .ram_rdata_i (ram_rdata_i),
    .mmio        (u_mmio_bus.fabric)
  );

  // gpio read returns the pad drive seen after override
  mmio_regfile u_mmio_regfile (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .bus               (u_mmio_bus.regs),
    .cfg               (u_pad_cfg.regs),
    .gpio_pad_i        (gpio_out_o),
    .gpio_in_i         (gpio_in_i),
    .hk_config_i       (hk_config_i),
    .hk_xtal_ena_i     (hk_xtal_ena_i),
    .hk_reg_ena_i      (hk_reg_ena_i),
    .hk_pll_cp_ena_i   (hk_pll_cp_ena_i),
    .hk_pll_vco_ena_i  (hk_pll_vco_ena_i),
    .hk_pll_bias_ena_i (hk_pll_bias_ena_i),
    .hk_pll_trim_i     (hk_pll_trim_i),
    .hk_mfgr_id_i      (hk_mfgr_id_i),
    .hk_prod_id_i      (hk_prod_id_i),
    .hk_mask_rev_i     (hk_mask_rev_i),
    .clk_ext_sel_i     (clk_ext_sel_i)
  );

  gpio_pin_mux u_gpio_pin_mux (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .cfg              (u_pad_cfg.pins),
    .trap_i           (trap_i),
    .irq_pin_i        (irq_pin_i),
    .irq_spi_i        (irq_spi_i),
    .gpio_in_i        (gpio_in_i),
    .gpio_out_o       (gpio_out_o),
    .gpio_outenb_o    (gpio_outenb_o),
    .gpio_pullupb_o   (gpio_pullupb_o),
    .gpio_pulldownb_o (gpio_pulldownb_o),
    .irq_o            (irq_o)
  );

endmodule

`default_nettype wire

// ==== hw/gpio_pin_mux.sv ====
// GPIO pad override for clock and trap routing, plus irq source select and vector
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module gpio_pin_mux (
  input  wire               clk_i,
  input  wire               rst_n_i,
  pad_cfg_if.pins           cfg,
  input  wire               trap_i,
  input  wire               irq_pin_i,
  input  wire               irq_spi_i,
  input  soc_pkg::gpio_t    gpio_in_i,
  output soc_pkg::gpio_t    gpio_out_o,
  output soc_pkg::gpio_t    gpio_outenb_o,
  output soc_pkg::gpio_t    gpio_pullupb_o,
  output soc_pkg::gpio_t    gpio_pulldownb_o,
  output soc_pkg::irq_vec_t irq_o
);
  import soc_pkg::*;

  // pads 8-10 and 11-13
  localparam gpio_t pll_grp  = 16'h0700;
  localparam gpio_t trap_grp = 16'h3800;

  gpio_t force_mask;

  function automatic logic irq_pick(irq_src_e src, logic [2:0] in);
    logic res;
    case (src)
      IRQ_IN_A: res = in[0];
      IRQ_IN_B: res = in[1];
      IRQ_IN_C: res = in[2];
      default:  res = 1'b0;
    endcase
    return res;
  endfunction

  assign force_mask = ((cfg.pll_dest != PLL_NONE) ? pll_grp : '0) |
                      ((cfg.trap_dest != TRAP_NONE) ? trap_grp : '0);

  always_comb begin
    gpio_out_o = cfg.gpio;
    if (cfg.pll_dest == PLL_GPIO8) gpio_out_o[8] = clk_i;
    if (cfg.pll_dest == PLL_GPIO9) gpio_out_o[9] = clk_i;
    if (cfg.trap_dest == TRAP_GPIO11) gpio_out_o[11] = trap_i;
    if (cfg.trap_dest == TRAP_GPIO12) gpio_out_o[12] = trap_i;
    if (cfg.trap_dest == TRAP_GPIO13) gpio_out_o[13] = trap_i;
  end

  // outputs stay off while in reset
  assign gpio_outenb_o    = {`SOC_GPIO_W{~rst_n_i}} | (cfg.gpio_oeb & ~force_mask);
  assign gpio_pullupb_o   = cfg.gpio_pu | force_mask;
  assign gpio_pulldownb_o = cfg.gpio_pd | force_mask;

  always_comb begin
    irq_o = '0;
    irq_o[`SOC_IRQ_PIN] = irq_pin_i;
    irq_o[`SOC_IRQ_SPI] = irq_spi_i;
    irq_o[`SOC_IRQ_7]   = irq_pick(cfg.irq7_src, gpio_in_i[2:0]);
    irq_o[`SOC_IRQ_8]   = irq_pick(cfg.irq8_src, gpio_in_i[5:3]);
  end

endmodule

`default_nettype wire

// ==== hw/mmio_regfile.sv ====
// native MMIO register block for GPIO, housekeeping status and pad routing
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module mmio_regfile (
  input  wire            clk_i,
  input  wire            rst_n_i,
  mmio_bus_if.regs       bus,
  pad_cfg_if.regs        cfg,
  input  soc_pkg::gpio_t gpio_pad_i,
  input  soc_pkg::gpio_t gpio_in_i,
  input  wire [7:0]      hk_config_i,
  input  wire            hk_xtal_ena_i,
  input  wire            hk_reg_ena_i,
  input  wire            hk_pll_cp_ena_i,
  input  wire            hk_pll_vco_ena_i,
  input  wire            hk_pll_bias_ena_i,
  input  wire [3:0]      hk_pll_trim_i,
  input  wire [11:0]     hk_mfgr_id_i,
  input  wire [7:0]      hk_prod_id_i,
  input  wire [3:0]      hk_mask_rev_i,
  input  wire            clk_ext_sel_i
);
  import soc_pkg::*;

  gpio_t      gpio_q;
  gpio_t      oeb_q;
  gpio_t      pu_q;
  gpio_t      pd_q;
  pll_dest_e  pll_dest_q;
  trap_dest_e trap_dest_q;
  irq_src_e   irq7_src_q;
  irq_src_e   irq8_src_q;
  logic       ready_q;
  word_t      rdata_q;
  word_t      rd_word;
  logic       access;

  // byte lanes 0 and 1 of a 16 bit register
  function automatic gpio_t lane_merge(gpio_t cur, word_t wdata, strb_t strb);
    gpio_t res;
    res = cur;
    if (strb[0]) res[7:0] = wdata[7:0];
    if (strb[1]) res[15:8] = wdata[15:8];
    return res;
  endfunction

  // one access per valid, ready drops after a single cycle
  assign access = bus.valid && !ready_q;

  always_comb begin
    rd_word = '0;
    case (bus.addr[7:0])
      `SOC_REG_GPIO:      rd_word = {gpio_pad_i, gpio_in_i};
      `SOC_REG_GPIO_OEB:  rd_word = word_t'(oeb_q);
      `SOC_REG_GPIO_PU:   rd_word = word_t'(pu_q);
      `SOC_REG_GPIO_PD:   rd_word = word_t'(pd_q);
      `SOC_REG_HK_CFG:    rd_word = word_t'(hk_config_i);
      `SOC_REG_HK_ENA:    rd_word = word_t'({hk_xtal_ena_i, hk_reg_ena_i});
      `SOC_REG_HK_PLL: begin
        rd_word = word_t'({hk_pll_trim_i, hk_pll_cp_ena_i, hk_pll_vco_ena_i, hk_pll_bias_ena_i});
      end
      `SOC_REG_HK_MFGR:   rd_word = word_t'(hk_mfgr_id_i);
      `SOC_REG_HK_PROD:   rd_word = word_t'(hk_prod_id_i);
      `SOC_REG_HK_MASK:   rd_word = word_t'(hk_mask_rev_i);
      `SOC_REG_CLK_SEL:   rd_word = word_t'(clk_ext_sel_i);
      `SOC_REG_PLL_DEST:  rd_word = word_t'(pll_dest_q);
      `SOC_REG_TRAP_DEST: rd_word = word_t'(trap_dest_q);
      `SOC_REG_IRQ7_SRC:  rd_word = word_t'(irq7_src_q);
      `SOC_REG_IRQ8_SRC:  rd_word = word_t'(irq8_src_q);
      default:            rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ready_q     <= 1'b0;
      gpio_q      <= '0;
      oeb_q       <= '1;
      pu_q        <= '0;
      pd_q        <= '0;
      pll_dest_q  <= PLL_NONE;
      trap_dest_q <= TRAP_NONE;
      irq7_src_q  <= IRQ_OFF;
      irq8_src_q  <= IRQ_OFF;
    end else begin
      ready_q <= access;
      if (access) begin
        case (bus.addr[7:0])
          `SOC_REG_GPIO:     gpio_q <= lane_merge(gpio_q, bus.wdata, bus.wstrb);
          `SOC_REG_GPIO_OEB: oeb_q <= lane_merge(oeb_q, bus.wdata, bus.wstrb);
          `SOC_REG_GPIO_PU:  pu_q <= lane_merge(pu_q, bus.wdata, bus.wstrb);
          `SOC_REG_GPIO_PD:  pd_q <= lane_merge(pd_q, bus.wdata, bus.wstrb);
          `SOC_REG_PLL_DEST: begin
            if (bus.wstrb[0]) pll_dest_q <= pll_dest_e'(bus.wdata[1:0]);
          end
          `SOC_REG_TRAP_DEST: begin
            if (bus.wstrb[0]) trap_dest_q <= trap_dest_e'(bus.wdata[1:0]);
          end
          `SOC_REG_IRQ7_SRC: begin
            if (bus.wstrb[0]) irq7_src_q <= irq_src_e'(bus.wdata[1:0]);
          end
          `SOC_REG_IRQ8_SRC: begin
            if (bus.wstrb[0]) irq8_src_q <= irq_src_e'(bus.wdata[1:0]);
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      rdata_q <= rd_word;
    end
  end

  assign bus.ready = ready_q;
  assign bus.rdata = rdata_q;

  assign cfg.gpio      = gpio_q;
  assign cfg.gpio_oeb  = oeb_q;
  assign cfg.gpio_pu   = pu_q;
  assign cfg.gpio_pd   = pd_q;
  assign cfg.pll_dest  = pll_dest_q;
  assign cfg.trap_dest = trap_dest_q;
  assign cfg.irq7_src  = irq7_src_q;
  assign cfg.irq8_src  = irq8_src_q;

endmodule

`default_nettype wire

// ==== hw/bus_fabric.sv ====
// native bus decode to SRAM and MMIO page, SRAM ready register and response mux
`timescale 1ns/1ps
`default_nettype none

`include "soc_defs.svh"

module bus_fabric (
  input  wire                clk_i,
  input  wire                rst_n_i,
  input  wire                mem_valid_i,
  input  soc_pkg::word_t     mem_addr_i,
  input  soc_pkg::word_t     mem_wdata_i,
  input  soc_pkg::strb_t     mem_wstrb_i,
  output logic               mem_ready_o,
  output soc_pkg::word_t     mem_rdata_o,
  output soc_pkg::strb_t     ram_wstrb_o,
  output soc_pkg::ram_addr_t ram_addr_o,
  output soc_pkg::word_t     ram_wdata_o,
  input  soc_pkg::word_t     ram_rdata_i,
  mmio_bus_if.fabric         mmio
);

  localparam int unsigned ram_aw = $clog2(`SOC_MEM_WORDS);

  logic ram_sel;
  logic ram_ready_q;
  logic mmio_hit;

  // SRAM access open until its ready comes back
  assign ram_sel = mem_valid_i && !ram_ready_q && (mem_addr_i < `SOC_RAM_TOP);

  assign ram_wstrb_o = ram_sel ? mem_wstrb_i : 4'h0;
  assign ram_addr_o  = mem_addr_i[ram_aw+1:2];
  assign ram_wdata_o = mem_wdata_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ram_ready_q <= 1'b0;
    end else begin
      ram_ready_q <= ram_sel;
    end
  end

  assign mmio.valid = mem_valid_i && (mem_addr_i[31:8] == `SOC_MMIO_PAGE);
  assign mmio.addr  = mem_addr_i;
  assign mmio.wdata = mem_wdata_i;
  assign mmio.wstrb = mem_wstrb_i;

  // mmio wins over sram
  assign mmio_hit = mmio.valid && mmio.ready;

  assign mem_ready_o = mmio_hit || ram_ready_q;
  assign mem_rdata_o = mmio_hit    ? mmio.rdata  :
                       ram_ready_q ? ram_rdata_i : '0;

endmodule

`default_nettype wire

// ==== hw/soc_ifs.sv ====
// internal MMIO request bus and pad configuration bundle between fabric, regs and pins
`timescale 1ns/1ps
`default_nettype none

interface mmio_bus_if;
  import soc_pkg::*;

  logic  valid;
  word_t addr;
  word_t wdata;
  strb_t wstrb;
  logic  ready;
  word_t rdata;

  modport fabric (output valid, addr, wdata, wstrb, input ready, rdata);
  modport regs (input valid, addr, wdata, wstrb, output ready, rdata);
endinterface

interface pad_cfg_if;
  import soc_pkg::*;

  gpio_t      gpio;
  gpio_t      gpio_oeb;
  gpio_t      gpio_pu;
  gpio_t      gpio_pd;
  pll_dest_e  pll_dest;
  trap_dest_e trap_dest;
  irq_src_e   irq7_src;
  irq_src_e   irq8_src;

  // plain levels, no handshake
  modport regs (output gpio, gpio_oeb, gpio_pu, gpio_pd, pll_dest, trap_dest, irq7_src, irq8_src);
  modport pins (input gpio, gpio_oeb, gpio_pu, gpio_pd, pll_dest, trap_dest, irq7_src, irq8_src);
endinterface

`default_nettype wire

// ==== hw/soc_pkg.sv ====
// shared bus vector types and routing selector enums, imported by the SoC RTL
`default_nettype none

`include "soc_defs.svh"

package soc_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0] strb_t;
  typedef logic [`SOC_GPIO_W-1:0] gpio_t;
  typedef logic [$clog2(`SOC_MEM_WORDS)-1:0] ram_addr_t;
  typedef logic [31:0] irq_vec_t;

  // clock out on one of two pads
  typedef enum logic [1:0] {
    PLL_NONE  = 2'd0,
    PLL_GPIO8 = 2'd1,
    PLL_GPIO9 = 2'd2
  } pll_dest_e;

  typedef enum logic [1:0] {
    TRAP_NONE   = 2'd0,
    TRAP_GPIO11 = 2'd1,
    TRAP_GPIO12 = 2'd2,
    TRAP_GPIO13 = 2'd3
  } trap_dest_e;

  // one of three gpio inputs, or off
  typedef enum logic [1:0] {
    IRQ_OFF  = 2'd0,
    IRQ_IN_A = 2'd1,
    IRQ_IN_B = 2'd2,
    IRQ_IN_C = 2'd3
  } irq_src_e;

endpackage

`default_nettype wire

// ==== hw/soc_defs.svh ====
// address map, memory size and register offsets, included by RTL and testbench
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

`define SOC_MEM_WORDS     32768
`define SOC_RAM_TOP       (32'd4 * `SOC_MEM_WORDS)
`define SOC_MMIO_PAGE     24'h03_0000

// offsets within the MMIO page
`define SOC_REG_GPIO      8'h00
`define SOC_REG_GPIO_OEB  8'h04
`define SOC_REG_GPIO_PU   8'h08
`define SOC_REG_GPIO_PD   8'h0c
`define SOC_REG_HK_CFG    8'h18
`define SOC_REG_HK_ENA    8'h1c
`define SOC_REG_HK_PLL    8'h20
`define SOC_REG_HK_MFGR   8'h24
`define SOC_REG_HK_PROD   8'h28
`define SOC_REG_HK_MASK   8'h2c
`define SOC_REG_CLK_SEL   8'h30
`define SOC_REG_PLL_DEST  8'h38
`define SOC_REG_TRAP_DEST 8'h3c
`define SOC_REG_IRQ7_SRC  8'h40
`define SOC_REG_IRQ8_SRC  8'h44

`define SOC_GPIO_W        16

`define SOC_IRQ_PIN       5
`define SOC_IRQ_SPI       6
`define SOC_IRQ_7         7
`define SOC_IRQ_8         8

`endif
